// ==== hdl/udp_loop_pkg.sv ====
////////////////////////////////////////////////////////////
// Shared widths, loopback port and state encodings for the
// UDP payload loopback path. Every module imports this.
////////////////////////////////////////////////////////////

package udp_loop_pkg;

  // Stream geometry
  localparam int WIDE_BYTES   = 8;
  localparam int NARROW_BYTES = 6;
  localparam int BYTE_W       = 8;
  localparam int WIDE_W       = WIDE_BYTES * BYTE_W;
  localparam int NARROW_W     = NARROW_BYTES * BYTE_W;

  // UDP destination port match
  localparam int PORT_W = 16;

  // Narrow FIFO size
  localparam int FIFO_DEPTH = 512;
  localparam int FIFO_AW    = 9;

  // Residue buffer shared by both width adapters
  localparam int RESID_BYTES = WIDE_BYTES + NARROW_BYTES;
  localparam int RESID_W     = RESID_BYTES * BYTE_W;
  localparam int RESID_CNT_W = 4;

  typedef logic [WIDE_W-1:0]       wide_data_t;
  typedef logic [WIDE_BYTES-1:0]   wide_keep_t;
  typedef logic [NARROW_W-1:0]     narrow_data_t;
  typedef logic [NARROW_BYTES-1:0] narrow_keep_t;
  typedef logic [PORT_W-1:0]       port_t;
  typedef logic [RESID_W-1:0]      resid_data_t;
  typedef logic [RESID_CNT_W-1:0]  resid_cnt_t;

  localparam port_t LOOP_PORT = 16'd1234;

  // Per-frame pass or drop decision
  typedef enum logic [1:0] {
    FILT_IDLE,
    FILT_PASS,
    FILT_DROP
  } filter_state_t;

  // Downsizer emptying its residue after a last beat
  typedef enum logic {
    PACK_RUN,
    PACK_FLUSH
  } pack_state_t;

endpackage

// ==== hdl/udp_port_filter.sv ====
////////////////////////////////////////////////////////////
// Input side of the loopback path. Frames whose UDP
// destination port matches the loopback port go on to the
// f_ stream, all others are accepted and thrown away.
////////////////////////////////////////////////////////////

module udp_port_filter (
  input  logic                     clk_x1,
  input  logic                     rst,
  input  udp_loop_pkg::wide_data_t in_data,
  input  udp_loop_pkg::wide_keep_t in_keep,
  input  logic                     in_valid,
  output logic                     in_ready,
  input  logic                     in_last,
  input  logic                     in_user,
  input  udp_loop_pkg::port_t      in_dest_port,
  output udp_loop_pkg::wide_data_t f_data,
  output udp_loop_pkg::wide_keep_t f_keep,
  output logic                     f_valid,
  input  logic                     f_ready,
  output logic                     f_last,
  output logic                     f_user
);

  import udp_loop_pkg::*;

  filter_state_t state_q;
  logic          pass_now;
  logic          in_fire;

  // First beat decides from the port, later beats follow the held decision
  always_comb begin
    unique case (state_q)
      FILT_IDLE: pass_now = (in_dest_port == LOOP_PORT);
      FILT_PASS: pass_now = 1'b1;
      default:   pass_now = 1'b0;
    endcase
  end

  assign f_data  = in_data;
  assign f_keep  = in_keep;
  assign f_last  = in_last;
  assign f_user  = in_user;
  assign f_valid = in_valid && pass_now;

  // Dropped frames are swallowed at full rate
  assign in_ready = pass_now ? f_ready : 1'b1;
  assign in_fire  = in_valid && in_ready;

  always_ff @(posedge clk_x1) begin
    if (rst) begin
      state_q <= FILT_IDLE;
    end else if (in_fire) begin
      if (in_last) begin
        state_q <= FILT_IDLE;
      end else if (state_q == FILT_IDLE) begin
        state_q <= pass_now ? FILT_PASS : FILT_DROP;
      end
    end
  end

endmodule

// ==== hdl/lane_downsizer.sv ====
////////////////////////////////////////////////////////////
// Width adapter from eight byte lanes to six. Accepted bytes
// gather in a residue buffer and leave six at a time; the
// tail of each frame is flushed with a partial keep.
////////////////////////////////////////////////////////////

module lane_downsizer (
  input  logic                       clk_x1,
  input  logic                       rst,
  input  udp_loop_pkg::wide_data_t   f_data,
  input  udp_loop_pkg::wide_keep_t   f_keep,
  input  logic                       f_valid,
  output logic                       f_ready,
  input  logic                       f_last,
  input  logic                       f_user,
  output udp_loop_pkg::narrow_data_t n_data,
  output udp_loop_pkg::narrow_keep_t n_keep,
  output logic                       n_valid,
  input  logic                       n_ready,
  output logic                       n_last,
  output logic                       n_user
);

  import udp_loop_pkg::*;

  pack_state_t state_q;
  resid_data_t res_q;
  resid_data_t res_d;
  resid_cnt_t  fill_q;
  resid_cnt_t  fill_d;
  resid_cnt_t  in_cnt;
  resid_cnt_t  out_cnt;
  resid_cnt_t  base_cnt;
  wide_data_t  in_masked;
  logic        user_q;
  logic        f_fire;
  logic        n_fire;

  // Count valid input lanes and clear the unused ones
  always_comb begin
    in_cnt    = '0;
    in_masked = '0;
    for (int i = 0; i < WIDE_BYTES; i++) begin
      if (f_keep[i]) begin
        in_cnt = in_cnt + 1'b1;
        in_masked[i*BYTE_W +: BYTE_W] = f_data[i*BYTE_W +: BYTE_W];
      end
    end
  end

  assign n_valid = (state_q == PACK_FLUSH) ? (fill_q != '0)
                                           : (fill_q >= resid_cnt_t'(NARROW_BYTES));
  assign n_last  = (state_q == PACK_FLUSH) && (fill_q <= resid_cnt_t'(NARROW_BYTES));
  assign n_data  = res_q[NARROW_W-1:0];
  assign n_user  = n_last && user_q;

  always_comb begin
    for (int i = 0; i < NARROW_BYTES; i++) begin
      n_keep[i] = (resid_cnt_t'(i) < fill_q);
    end
  end

  // Room for a whole wide beat, and nothing taken while flushing
  assign f_ready = (state_q == PACK_RUN) &&
                   (fill_q <= resid_cnt_t'(RESID_BYTES - WIDE_BYTES));

  assign f_fire = f_valid && f_ready;
  assign n_fire = n_valid && n_ready;

  // Shift out the emitted lanes, then append the new beat behind the rest
  always_comb begin
    out_cnt = '0;
    if (n_fire) begin
      out_cnt = (fill_q >= resid_cnt_t'(NARROW_BYTES)) ? resid_cnt_t'(NARROW_BYTES) : fill_q;
    end
    base_cnt = fill_q - out_cnt;
    res_d    = res_q >> (out_cnt * BYTE_W);
    fill_d   = base_cnt;
    if (f_fire) begin
      res_d  = res_d | (resid_data_t'(in_masked) << (base_cnt * BYTE_W));
      fill_d = base_cnt + in_cnt;
    end
  end

  always_ff @(posedge clk_x1) begin
    if (rst) begin
      state_q <= PACK_RUN;
      res_q   <= '0;
      fill_q  <= '0;
      user_q  <= 1'b0;
    end else begin
      res_q  <= res_d;
      fill_q <= fill_d;
      if (f_fire) begin
        user_q <= user_q | f_user;
        if (f_last) begin
          state_q <= PACK_FLUSH;
        end
      end
      if (n_fire && n_last) begin
        state_q <= PACK_RUN;
        user_q  <= 1'b0;
      end
    end
  end

endmodule

// ==== hdl/narrow_frame_fifo.sv ====
////////////////////////////////////////////////////////////
// FIFO of six-lane beats between the two width adapters.
// A registered output stage sits behind the memory, with a
// bypass so a write into an empty FIFO shows next cycle.
////////////////////////////////////////////////////////////

module narrow_frame_fifo (
  input  logic                       clk_x1,
  input  logic                       rst,
  input  udp_loop_pkg::narrow_data_t n_data,
  input  udp_loop_pkg::narrow_keep_t n_keep,
  input  logic                       n_valid,
  output logic                       n_ready,
  input  logic                       n_last,
  input  logic                       n_user,
  output udp_loop_pkg::narrow_data_t q_data,
  output udp_loop_pkg::narrow_keep_t q_keep,
  output logic                       q_valid,
  input  logic                       q_ready,
  output logic                       q_last,
  output logic                       q_user
);

  import udp_loop_pkg::*;

  // Word layout is user, last, keep, data
  logic [NARROW_W+NARROW_BYTES+1:0] mem [FIFO_DEPTH];
  logic [NARROW_W+NARROW_BYTES+1:0] n_word;
  logic [NARROW_W+NARROW_BYTES+1:0] out_word_q;
  logic [FIFO_AW-1:0]               wr_ptr;
  logic [FIFO_AW-1:0]               rd_ptr;
  logic [FIFO_AW:0]                 count_q;
  logic                             push;
  logic                             load;
  logic                             mem_rd;
  logic                             mem_wr;
  logic                             bypass;

  assign n_word = {n_user, n_last, n_keep, n_data};
  assign {q_user, q_last, q_keep, q_data} = out_word_q;

  assign n_ready = (count_q != (FIFO_AW + 1)'(FIFO_DEPTH));
  assign push    = n_valid && n_ready;

  // Output stage refills when empty or being drained
  assign load   = !q_valid || q_ready;
  assign mem_rd = load && (count_q != '0);
  assign bypass = load && (count_q == '0) && push;
  assign mem_wr = push && !bypass;

  always_ff @(posedge clk_x1) begin
    if (mem_wr) begin
      mem[wr_ptr] <= n_word;
    end
  end

  always_ff @(posedge clk_x1) begin
    if (mem_rd) begin
      out_word_q <= mem[rd_ptr];
    end else if (bypass) begin
      out_word_q <= n_word;
    end
  end

  always_ff @(posedge clk_x1) begin
    if (rst) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count_q <= '0;
      q_valid <= 1'b0;
    end else begin
      if (mem_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (mem_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (mem_wr && !mem_rd) begin
        count_q <= count_q + 1'b1;
      end else if (mem_rd && !mem_wr) begin
        count_q <= count_q - 1'b1;
      end
      if (load) begin
        q_valid <= mem_rd || bypass;
      end
    end
  end

endmodule

// ==== hdl/lane_upsizer.sv ====
////////////////////////////////////////////////////////////
// Width adapter from six byte lanes back to eight. Narrow
// lanes gather in a byte buffer; a wide beat leaves when
// eight bytes are held or the frame's last lane is in.
////////////////////////////////////////////////////////////

module lane_upsizer (
  input  logic                       clk_x1,
  input  logic                       rst,
  input  udp_loop_pkg::narrow_data_t q_data,
  input  udp_loop_pkg::narrow_keep_t q_keep,
  input  logic                       q_valid,
  output logic                       q_ready,
  input  logic                       q_last,
  input  logic                       q_user,
  output udp_loop_pkg::wide_data_t   out_data,
  output udp_loop_pkg::wide_keep_t   out_keep,
  output logic                       out_valid,
  input  logic                       out_ready,
  output logic                       out_last,
  output logic                       out_user
);

  import udp_loop_pkg::*;

  resid_data_t  res_q;
  resid_data_t  res_d;
  resid_cnt_t   fill_q;
  resid_cnt_t   fill_d;
  resid_cnt_t   in_cnt;
  resid_cnt_t   out_cnt;
  resid_cnt_t   base_cnt;
  narrow_data_t in_masked;
  logic         last_q;
  logic         user_q;
  logic         q_fire;
  logic         out_fire;

  always_comb begin
    in_cnt    = '0;
    in_masked = '0;
    for (int i = 0; i < NARROW_BYTES; i++) begin
      if (q_keep[i]) begin
        in_cnt = in_cnt + 1'b1;
        in_masked[i*BYTE_W +: BYTE_W] = q_data[i*BYTE_W +: BYTE_W];
      end
    end
  end

  // last_q means the frame end is already in the buffer
  assign out_valid = (fill_q >= resid_cnt_t'(WIDE_BYTES)) || (last_q && (fill_q != '0));
  assign out_last  = last_q && (fill_q <= resid_cnt_t'(WIDE_BYTES));
  assign out_data  = res_q[WIDE_W-1:0];
  assign out_user  = out_last && user_q;

  always_comb begin
    for (int i = 0; i < WIDE_BYTES; i++) begin
      out_keep[i] = (resid_cnt_t'(i) < fill_q);
    end
  end

  // Next frame waits until the current tail has gone out
  assign q_ready = !last_q && (fill_q <= resid_cnt_t'(RESID_BYTES - NARROW_BYTES));

  assign q_fire   = q_valid && q_ready;
  assign out_fire = out_valid && out_ready;

  always_comb begin
    out_cnt = '0;
    if (out_fire) begin
      out_cnt = (fill_q >= resid_cnt_t'(WIDE_BYTES)) ? resid_cnt_t'(WIDE_BYTES) : fill_q;
    end
    base_cnt = fill_q - out_cnt;
    res_d    = res_q >> (out_cnt * BYTE_W);
    fill_d   = base_cnt;
    if (q_fire) begin
      res_d  = res_d | (resid_data_t'(in_masked) << (base_cnt * BYTE_W));
      fill_d = base_cnt + in_cnt;
    end
  end

  always_ff @(posedge clk_x1) begin
    if (rst) begin
      res_q  <= '0;
      fill_q <= '0;
      last_q <= 1'b0;
      user_q <= 1'b0;
    end else begin
      res_q  <= res_d;
      fill_q <= fill_d;
      if (q_fire) begin
        user_q <= user_q | q_user;
        if (q_last) begin
          last_q <= 1'b1;
        end
      end
      if (out_fire && out_last) begin
        last_q <= 1'b0;
        user_q <= 1'b0;
      end
    end
  end

endmodule

// ==== hdl/led_first_byte.sv ====
////////////////////////////////////////////////////////////
// Shows the first payload byte of every passed frame on
// the LEDs, taken from the filter's output stream.
////////////////////////////////////////////////////////////

module led_first_byte (
  input  logic                            clk_x1,
  input  logic                            rst,
  input  udp_loop_pkg::wide_data_t        f_data,
  input  logic                            f_valid,
  input  logic                            f_ready,
  input  logic                            f_last,
  output logic [udp_loop_pkg::BYTE_W-1:0] led
);

  import udp_loop_pkg::*;

  logic first_q;
  logic f_fire;

  assign f_fire = f_valid && f_ready;

  always_ff @(posedge clk_x1) begin
    if (rst) begin
      first_q <= 1'b1;
      led     <= '0;
    end else if (f_fire) begin
      // Low lane holds the first payload byte
      if (first_q) begin
        led <= f_data[BYTE_W-1:0];
      end
      first_q <= f_last;
    end
  end

endmodule

// ==== hdl/udp_loop_top.sv ====
////////////////////////////////////////////////////////////
// UDP payload loopback: port filter, 8 to 6 lane adapter,
// narrow FIFO, 6 to 8 lane adapter and the LED display.
////////////////////////////////////////////////////////////

module udp_loop_top (
  input  logic                            clk_x1,
  input  logic                            rst,
  input  udp_loop_pkg::wide_data_t        in_data,
  input  udp_loop_pkg::wide_keep_t        in_keep,
  input  logic                            in_valid,
  output logic                            in_ready,
  input  logic                            in_last,
  input  logic                            in_user,
  input  udp_loop_pkg::port_t             in_dest_port,
  output udp_loop_pkg::wide_data_t        out_data,
  output udp_loop_pkg::wide_keep_t        out_keep,
  output logic                            out_valid,
  input  logic                            out_ready,
  output logic                            out_last,
  output logic                            out_user,
  output logic [udp_loop_pkg::BYTE_W-1:0] led
);

  import udp_loop_pkg::*;

  // Passed frames, eight lanes
  wide_data_t   f_data;
  wide_keep_t   f_keep;
  logic         f_valid;
  logic         f_ready;
  logic         f_last;
  logic         f_user;

  // Downsizer to FIFO, six lanes
  narrow_data_t n_data;
  narrow_keep_t n_keep;
  logic         n_valid;
  logic         n_ready;
  logic         n_last;
  logic         n_user;

  // FIFO to upsizer
  narrow_data_t q_data;
  narrow_keep_t q_keep;
  logic         q_valid;
  logic         q_ready;
  logic         q_last;
  logic         q_user;

  udp_port_filter u_filter (
    .clk_x1      (clk_x1),
    .rst         (rst),
    .in_data     (in_data),
    .in_keep     (in_keep),
    .in_valid    (in_valid),
    .in_ready    (in_ready),
    .in_last     (in_last),
    .in_user     (in_user),
    .in_dest_port(in_dest_port),
    .f_data      (f_data),
    .f_keep      (f_keep),
    .f_valid     (f_valid),
    .f_ready     (f_ready),
    .f_last      (f_last),
    .f_user      (f_user)
  );

  lane_downsizer u_down (
    .clk_x1 (clk_x1),
    .rst    (rst),
    .f_data (f_data),
    .f_keep (f_keep),
    .f_valid(f_valid),
    .f_ready(f_ready),
    .f_last (f_last),
    .f_user (f_user),
    .n_data (n_data),
    .n_keep (n_keep),
    .n_valid(n_valid),
    .n_ready(n_ready),
    .n_last (n_last),
    .n_user (n_user)
  );

  narrow_frame_fifo u_fifo (
    .clk_x1 (clk_x1),
    .rst    (rst),
    .n_data (n_data),
    .n_keep (n_keep),
    .n_valid(n_valid),
    .n_ready(n_ready),
    .n_last (n_last),
    .n_user (n_user),
    .q_data (q_data),
    .q_keep (q_keep),
    .q_valid(q_valid),
    .q_ready(q_ready),
    .q_last (q_last),
    .q_user (q_user)
  );

  lane_upsizer u_up (
    .clk_x1   (clk_x1),
    .rst      (rst),
    .q_data   (q_data),
    .q_keep   (q_keep),
    .q_valid  (q_valid),
    .q_ready  (q_ready),
    .q_last   (q_last),
    .q_user   (q_user),
    .out_data (out_data),
    .out_keep (out_keep),
    .out_valid(out_valid),
    .out_ready(out_ready),
    .out_last (out_last),
    .out_user (out_user)
  );

  led_first_byte u_led (
    .clk_x1 (clk_x1),
    .rst    (rst),
    .f_data (f_data),
    .f_valid(f_valid),
    .f_ready(f_ready),
    .f_last (f_last),
    .led    (led)
  );

endmodule

// ==== sim/tb_udp_loop.sv ====
////////////////////////////////////////////////////////////
// Directed testbench for the UDP payload loopback top level.
// Frames go in on the in_ stream, and the out_ stream is
// collected and compared with a repacked byte model.
////////////////////////////////////////////////////////////

module tb_udp_loop;

  import udp_loop_pkg::*;

  localparam int    WAIT_LIMIT = 2000;
  localparam port_t OTHER_PORT = 16'd5353;

  logic        clk_x1;
  logic        rst;
  wide_data_t  in_data;
  wide_keep_t  in_keep;
  logic        in_valid;
  logic        in_ready;
  logic        in_last;
  logic        in_user;
  port_t       in_dest_port;
  wide_data_t  out_data;
  wide_keep_t  out_keep;
  logic        out_valid;
  logic        out_ready;
  logic        out_last;
  logic        out_user;
  logic [7:0]  led;

  logic [15:0] lfsr_q;
  logic [7:0]  frame_bytes[$];
  wide_data_t  got_data[$];
  wide_keep_t  got_keep[$];
  logic        got_last[$];
  logic        got_user[$];
  int          errors;
  int          test_errors;
  int          tests_run;
  int          tests_failed;
  logic [7:0]  first_byte;

  udp_loop_top uut (
    .clk_x1      (clk_x1),
    .rst         (rst),
    .in_data     (in_data),
    .in_keep     (in_keep),
    .in_valid    (in_valid),
    .in_ready    (in_ready),
    .in_last     (in_last),
    .in_user     (in_user),
    .in_dest_port(in_dest_port),
    .out_data    (out_data),
    .out_keep    (out_keep),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .out_last    (out_last),
    .out_user    (out_user),
    .led         (led)
  );

  always #4 clk_x1 = ~clk_x1;

  // Output beats seen at the falling edge move on the next rising edge
  always @(negedge clk_x1) begin
    if (!rst && out_valid && out_ready) begin
      got_data.push_back(out_data);
      got_keep.push_back(out_keep);
      got_last.push_back(out_last);
      got_user.push_back(out_user);
    end
  end

  // Galois LFSR, taps for x^16 + x^14 + x^13 + x^11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  function automatic logic take_bit();
    logic b;
    b      = lfsr_q[0];
    lfsr_q = lfsr_step(lfsr_q);
    return b;
  endfunction

  function automatic logic [7:0] take_byte();
    logic [7:0] v;
    v = '0;
    for (int i = 0; i < 8; i++) begin
      v = {v[6:0], take_bit()};
    end
    return v;
  endfunction

  task automatic abort_run(input string why);
    $display("error at %0t: %s", $time, why);
    $display("test failed");
    $finish;
  endtask

  task automatic check_beat(input wide_data_t got_d, input wide_keep_t got_k,
                            input logic got_l, input logic got_u,
                            input wide_data_t exp_d, input wide_keep_t exp_k,
                            input logic exp_l, input logic exp_u, input string what);
    wide_data_t mask;
    mask = '0;
    // Only kept lanes carry payload
    for (int i = 0; i < WIDE_BYTES; i++) begin
      if (exp_k[i]) begin
        mask[i*BYTE_W +: BYTE_W] = 8'hff;
      end
    end
    if ((got_d & mask) !== exp_d || got_k !== exp_k || got_l !== exp_l || got_u !== exp_u) begin
      errors++;
      $display("mismatch at %0t: %s data %h exp %h keep %b exp %b", $time, what,
               got_d & mask, exp_d, got_k, exp_k);
      $display("  last %b exp %b user %b exp %b", got_l, exp_l, got_u, exp_u);
    end
  endtask

  task automatic check_led(input logic [7:0] got, input logic [7:0] exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s led %h exp %h", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s is %b exp %b", $time, what, got, exp);
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    if (got != exp) begin
      errors++;
      $display("mismatch at %0t: %s is %0d exp %0d", $time, what, got, exp);
    end
  endtask

  task automatic build_frame(input int len);
    frame_bytes.delete();
    for (int i = 0; i < len; i++) begin
      frame_bytes.push_back(take_byte());
    end
  endtask

  task automatic clear_output();
    got_data.delete();
    got_keep.delete();
    got_last.delete();
    got_user.delete();
  endtask

  // Drives frame_bytes as one frame, waiting on in_ready for every beat
  task automatic send_frame(input port_t port, input int user_beat, input logic must_stay_ready);
    int         nbeats;
    int         idx;
    int         waits;
    int         b;
    wide_data_t d;
    wide_keep_t k;
    nbeats = (frame_bytes.size() + WIDE_BYTES - 1) / WIDE_BYTES;
    @(posedge clk_x1);
    for (b = 0; b < nbeats; b++) begin
      d = '0;
      k = '0;
      for (int i = 0; i < WIDE_BYTES; i++) begin
        idx = b * WIDE_BYTES + i;
        if (idx < frame_bytes.size()) begin
          d[i*BYTE_W +: BYTE_W] = frame_bytes[idx];
          k[i] = 1'b1;
        end
      end
      in_data      <= d;
      in_keep      <= k;
      in_valid     <= 1'b1;
      in_last      <= (b == nbeats - 1);
      in_user      <= (b == user_beat);
      in_dest_port <= port;
      waits = 0;
      @(negedge clk_x1);
      while (!in_ready) begin
        if (must_stay_ready) begin
          errors++;
          $display("error at %0t: in_ready went low while a frame was dropped", $time);
        end
        waits++;
        if (waits > WAIT_LIMIT) begin
          abort_run("input beat was never accepted");
        end
        @(negedge clk_x1);
      end
      @(posedge clk_x1);
    end
    in_valid <= 1'b0;
    in_last  <= 1'b0;
    in_user  <= 1'b0;
  endtask

  task automatic wait_frame_out(input string what);
    int waits;
    waits = 0;
    while (!(got_last.size() > 0 && got_last[got_last.size()-1])) begin
      waits++;
      if (waits > WAIT_LIMIT) begin
        abort_run({"no output frame end arrived for ", what});
      end
      @(posedge clk_x1);
    end
  endtask

  // Random out_ready until the frame's last beat has left
  task automatic toggle_ready_until_last();
    int waits;
    waits = 0;
    while (!(got_last.size() > 0 && got_last[got_last.size()-1])) begin
      @(posedge clk_x1);
      out_ready <= take_bit();
      waits++;
      if (waits > WAIT_LIMIT) begin
        abort_run("output frame stalled under back-pressure");
      end
    end
    out_ready <= 1'b1;
  endtask

  // Expected beats are the frame bytes taken eight at a time
  task automatic compare_frame(input logic exp_user, input string what);
    int         nbeats;
    int         idx;
    wide_data_t exp_d;
    wide_keep_t exp_k;
    nbeats = (frame_bytes.size() + WIDE_BYTES - 1) / WIDE_BYTES;
    check_count(got_data.size(), nbeats, {what, " beat count"});
    for (int b = 0; b < nbeats && b < got_data.size(); b++) begin
      exp_d = '0;
      exp_k = '0;
      for (int i = 0; i < WIDE_BYTES; i++) begin
        idx = b * WIDE_BYTES + i;
        if (idx < frame_bytes.size()) begin
          exp_d[i*BYTE_W +: BYTE_W] = frame_bytes[idx];
          exp_k[i] = 1'b1;
        end
      end
      check_beat(got_data[b], got_keep[b], got_last[b], got_user[b], exp_d, exp_k,
                 b == nbeats - 1, (b == nbeats - 1) && exp_user,
                 $sformatf("%s beat %0d", what, b));
    end
  endtask

  task automatic pass_frame(input int len, input int user_beat, input string what);
    build_frame(len);
    send_frame(LOOP_PORT, user_beat, 1'b0);
    wait_frame_out(what);
    compare_frame(user_beat >= 0, what);
    check_led(led, frame_bytes[0], {"after ", what});
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (errors == test_errors) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: FAILED with %0d errors", tests_run, name, errors - test_errors);
    end
    test_errors = errors;
  endtask

  task automatic apply_reset();
    repeat (2) @(posedge clk_x1);
    rst <= 1'b0;
  endtask

  task automatic test_reset_state();
    @(negedge clk_x1);
    check_flag(out_valid, 1'b0, "out_valid after reset");
    check_flag(in_ready, 1'b1, "in_ready after reset");
    check_led(led, 8'h00, "after reset");
    finish_test("reset state");
  endtask

  task automatic test_single_frames();
    int lens[5];
    lens = '{1, 6, 8, 13, 24};
    foreach (lens[i]) begin
      clear_output();
      pass_frame(lens[i], -1, $sformatf("%0d-byte frame", lens[i]));
    end
    finish_test("single passed frames");
  endtask

  task automatic test_dropped_frame();
    clear_output();
    build_frame(16);
    send_frame(OTHER_PORT, -1, 1'b1);
    check_count(got_data.size(), 0, "beats out after the dropped frame");
    pass_frame(11, -1, "frame after a drop");
    finish_test("dropped frame");
  endtask

  task automatic test_back_pressure();
    build_frame(64);
    clear_output();
    fork
      send_frame(LOOP_PORT, -1, 1'b0);
      toggle_ready_until_last();
    join
    compare_frame(1'b0, "64-byte frame under back-pressure");
    check_led(led, frame_bytes[0], "after the back-pressure frame");
    finish_test("back-pressure");
  endtask

  task automatic test_user_flag();
    clear_output();
    pass_frame(20, 1, "frame with user on beat 1");
    // The flag must not leak into the next frame
    clear_output();
    pass_frame(10, -1, "clean frame after user");
    finish_test("user flag");
  endtask

  task automatic test_led();
    clear_output();
    pass_frame(8, -1, "led frame");
    first_byte = frame_bytes[0];
    check_led(led, first_byte, "after a passed frame");
    build_frame(8);
    frame_bytes[0] = ~first_byte;
    send_frame(OTHER_PORT, -1, 1'b1);
    @(negedge clk_x1);
    check_led(led, first_byte, "after a dropped frame");
    finish_test("led first byte");
  endtask

  initial begin
    clk_x1       = 1'b0;
    rst          = 1'b1;
    in_data      = '0;
    in_keep      = '0;
    in_valid     = 1'b0;
    in_last      = 1'b0;
    in_user      = 1'b0;
    in_dest_port = '0;
    out_ready    = 1'b1;
    lfsr_q       = 16'd87;
    errors       = 0;
    test_errors  = 0;
    tests_run    = 0;
    tests_failed = 0;
    apply_reset();
    test_reset_state();
    test_single_frames();
    test_dropped_frame();
    test_back_pressure();
    test_user_flag();
    test_led();
    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
hdl/udp_loop_pkg.sv
hdl/udp_port_filter.sv
hdl/lane_downsizer.sv
hdl/narrow_frame_fifo.sv
hdl/lane_upsizer.sv
hdl/led_first_byte.sv
hdl/udp_loop_top.sv
sim/tb_udp_loop.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile and run the UDP loopback testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f tb.f --top-module tb_udp_loop -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_udp_loop > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -qx "test passed" "$LOG"; then
  exit 0
else
  echo "pass message not found in $LOG"
  exit 1
fi
